//--- design/cpu8_pkg.sv
`default_nettype none

package cpu8_pkg;

    localparam int DATA_W     = 8;
    localparam int REG_ADDR_W = 3;
    localparam int PC_W       = 32;
    localparam int OPCODE_W   = 8;
    localparam int OFFSET_W   = 8;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [PC_W-1:0]       pc_t;
    typedef logic [31:0]           instr_t;

    // codes 8..11 and 13 and up are undefined and act as no-ops
    typedef enum logic [OPCODE_W-1:0] {
        OP_LOADI = 8'd0,
        OP_MOV   = 8'd1,
        OP_ADD   = 8'd2,
        OP_SUB   = 8'd3,
        OP_AND   = 8'd4,
        OP_OR    = 8'd5,
        OP_JUMP  = 8'd6,
        OP_BEQ   = 8'd7,
        OP_BNE   = 8'd12
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_PASS = 2'd0,
        ALU_ADD  = 2'd1,
        ALU_AND  = 2'd2,
        ALU_OR   = 2'd3
    } alu_op_e;

    typedef struct packed {
        opcode_e                opcode; // bits 31:24
        reg_addr_t              dest;   // bits 18:16
        reg_addr_t              src1;   // bits 10:8
        reg_addr_t              src2;   // bits 2:0
        data_t                  imm;    // bits 7:0
        logic [OFFSET_W-1:0]    offset; // bits 23:16, overlaps dest
    } instr_fields_t;

    typedef struct packed {
        alu_op_e alu_op;
        logic    negate;    // second operand becomes -b
        logic    use_imm;   // second operand becomes imm
        logic    reg_write;
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        data_t     data;
    } wb_t;

    localparam pc_t PC_STEP = 32'd4; // one instruction word

endpackage

`default_nettype wire

//--- design/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
    import cpu8_pkg::*;
(
    input  instr_t        instruction,
    output instr_fields_t fields,
    output ctrl_t         ctrl
);

    // field extraction, all fields sliced regardless of opcode
    always_comb
    begin
        fields.opcode = opcode_e'(instruction[31:24]);
        fields.dest   = instruction[18:16];
        fields.src1   = instruction[10:8];
        fields.src2   = instruction[2:0];
        fields.imm    = instruction[7:0];
        fields.offset = instruction[23:16];
    end

    always_comb
    begin
        ctrl = '0; // inactive unless the opcode says otherwise
        case (fields.opcode)
            OP_LOADI:
            begin
                ctrl.alu_op    = ALU_PASS;
                ctrl.use_imm   = 1'b1; // pass imm straight through
                ctrl.reg_write = 1'b1;
            end
            OP_MOV:
            begin
                ctrl.alu_op    = ALU_PASS; // pass src2
                ctrl.reg_write = 1'b1;
            end
            OP_ADD:
            begin
                ctrl.alu_op    = ALU_ADD;
                ctrl.reg_write = 1'b1;
            end
            OP_SUB:
            begin
                ctrl.alu_op    = ALU_ADD;
                ctrl.negate    = 1'b1; // a + (-b)
                ctrl.reg_write = 1'b1;
            end
            OP_AND:
            begin
                ctrl.alu_op    = ALU_AND;
                ctrl.reg_write = 1'b1;
            end
            OP_OR:
            begin
                ctrl.alu_op    = ALU_OR;
                ctrl.reg_write = 1'b1;
            end
            OP_JUMP:
            begin
                ctrl.jump = 1'b1;
            end
            OP_BEQ:
            begin
                ctrl.alu_op    = ALU_ADD; // difference is zero when equal
                ctrl.negate    = 1'b1;
                ctrl.branch_eq = 1'b1;
            end
            OP_BNE:
            begin
                ctrl.alu_op    = ALU_ADD;
                ctrl.negate    = 1'b1;
                ctrl.branch_ne = 1'b1;
            end
            default:
            begin
                ctrl = '0; // undefined code, no write, sequential pc
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import cpu8_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET,
    input  reg_addr_t src1,
    input  reg_addr_t src2,
    output data_t     data1,
    output data_t     data2,
    input  wb_t       wb
);

    data_t regs [2**REG_ADDR_W];

    // asynchronous reads, same-cycle operands for the alu
    assign data1 = regs[src1];
    assign data2 = regs[src2];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            for (int i = 0; i < 2**REG_ADDR_W; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb.valid)
        begin
            regs[wb.addr] <= wb.data; // write-back at the edge
        end
    end

endmodule

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import cpu8_pkg::*;
(
    input  ctrl_t ctrl,
    input  data_t a,
    input  data_t b,
    input  data_t imm,
    output data_t result,
    output logic  zero
);

    data_t operand; // selected second operand

    always_comb
    begin
        if (ctrl.use_imm)
        begin
            operand = imm;
        end
        else if (ctrl.negate)
        begin
            operand = ~b + 1'b1; // two's complement for sub and compare
        end
        else
        begin
            operand = b;
        end
    end

    always_comb
    begin
        case (ctrl.alu_op)
            ALU_PASS: result = operand;
            ALU_ADD:  result = a + operand; // wraps modulo 256
            ALU_AND:  result = a & operand;
            ALU_OR:   result = a | operand;
            default:  result = operand;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- design/target_calc.sv
`timescale 1ns/1ps
`default_nettype none

module target_calc
    import cpu8_pkg::*;
(
    input  pc_t                 pc,
    input  logic [OFFSET_W-1:0] offset,
    output pc_t                 seq_pc,
    output pc_t                 target
);

    pc_t offset_ext;     // sign-extended word offset
    pc_t offset_bytes;   // offset scaled to bytes

    assign offset_ext   = {{(PC_W-OFFSET_W){offset[OFFSET_W-1]}}, offset};
    assign offset_bytes = {offset_ext[PC_W-3:0], 2'b00};

    assign seq_pc = pc + PC_STEP;

    // relative to the following instruction
    assign target = seq_pc + offset_bytes;

endmodule

`default_nettype wire

//--- design/pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pc_unit
    import cpu8_pkg::*;
#(
    parameter pc_t RESET_PC = '0
)
(
    input  logic  CLK,
    input  logic  RESET,
    input  ctrl_t ctrl,
    input  logic  zero,
    input  pc_t   seq_pc,
    input  pc_t   target,
    output pc_t   pc
);

    logic take;    // branch or jump taken
    pc_t  next_pc;

    assign take = ctrl.jump
                | (ctrl.branch_eq & zero)
                | (ctrl.branch_ne & ~zero);

    assign next_pc = take ? target : seq_pc;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            pc <= RESET_PC;
        end
        else
        begin
            pc <= next_pc; // one instruction per clock
        end
    end

endmodule

`default_nettype wire

//--- design/cpu8_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu8_top
    import cpu8_pkg::*;
#(
    parameter pc_t RESET_PC = '0
)
(
    input  logic   CLK,
    input  logic   RESET,
    input  instr_t instruction,
    output pc_t    pc,
    output wb_t    wb
);

    instr_fields_t fields;
    ctrl_t         ctrl;
    data_t         data1;
    data_t         data2;
    data_t         alu_result;
    logic          zero;
    pc_t           seq_pc;
    pc_t           target;

    instr_decoder u_decoder (
        .instruction (instruction),
        .fields      (fields),
        .ctrl        (ctrl)
    );

    reg_file u_reg_file (
        .CLK   (CLK),
        .RESET (RESET),
        .src1  (fields.src1),
        .src2  (fields.src2),
        .data1 (data1),
        .data2 (data2),
        .wb    (wb)
    );

    alu u_alu (
        .ctrl   (ctrl),
        .a      (data1),
        .b      (data2),
        .imm    (fields.imm),
        .result (alu_result),
        .zero   (zero)
    );

    // runs beside the alu, pc_unit picks between its two addresses
    target_calc u_target_calc (
        .pc     (pc),
        .offset (fields.offset),
        .seq_pc (seq_pc),
        .target (target)
    );

    pc_unit #(
        .RESET_PC (RESET_PC)
    ) u_pc_unit (
        .CLK    (CLK),
        .RESET  (RESET),
        .ctrl   (ctrl),
        .zero   (zero),
        .seq_pc (seq_pc),
        .target (target),
        .pc     (pc)
    );

    // write-back port, also exported for observation
    assign wb.valid = ctrl.reg_write & ~RESET;
    assign wb.addr  = fields.dest;
    assign wb.data  = alu_result;

endmodule

`default_nettype wire

//--- bench/cpu8_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu8_tb
    import cpu8_pkg::*;
();

    localparam int  CLK_PERIOD    = 10;
    localparam int  RESET_CYCLES  = 16;
    localparam int  RESET_TIMEOUT = RESET_CYCLES;
    localparam pc_t START_PC      = '0; // core left at its default start address

    typedef struct packed {
        logic [7:0] opcode;
        reg_addr_t  dest;
        reg_addr_t  src1;
        reg_addr_t  src2;
        logic [7:0] imm_off; // imm, or offset for branch and jump
        wb_t        exp_wb;
        pc_t        exp_pc;  // pc after the edge
    } row_t;

    logic   CLK;
    logic   RESET;
    instr_t instruction;
    pc_t    pc;
    wb_t    wb;

    row_t table_rows[$];
    int   seed;
    int   checks;
    int   errors;
    logic reset_ok;

    cpu8_top uut (
        .CLK         (CLK),
        .RESET       (RESET),
        .instruction (instruction),
        .pc          (pc),
        .wb          (wb)
    );

    always #(CLK_PERIOD/2) CLK = ~CLK;

    task automatic add_row(input logic [7:0] opcode, input reg_addr_t dest,
                           input reg_addr_t src1, input reg_addr_t src2,
                           input logic [7:0] imm_off, input logic exp_valid,
                           input reg_addr_t exp_addr, input data_t exp_data,
                           input pc_t exp_pc);
        row_t r;
        r.opcode       = opcode;
        r.dest         = dest;
        r.src1         = src1;
        r.src2         = src2;
        r.imm_off      = imm_off;
        r.exp_wb.valid = exp_valid;
        r.exp_wb.addr  = exp_addr;
        r.exp_wb.data  = exp_data;
        r.exp_pc       = exp_pc;
        table_rows.push_back(r);
    endtask

    // opcode, dest, src1, src2, imm/offset, then expected valid, addr, data and next pc
    task automatic load_table();
        add_row(OP_LOADI, 3'd1, 3'd0, 3'd0, 8'h5A, 1'b1, 3'd1, 8'h5A, 32'h04);
        add_row(OP_LOADI, 3'd2, 3'd0, 3'd0, 8'h3C, 1'b1, 3'd2, 8'h3C, 32'h08);
        add_row(OP_MOV,   3'd3, 3'd0, 3'd1, 8'h00, 1'b1, 3'd3, 8'h5A, 32'h0C);
        add_row(OP_ADD,   3'd4, 3'd1, 3'd2, 8'h00, 1'b1, 3'd4, 8'h96, 32'h10);
        add_row(OP_SUB,   3'd5, 3'd1, 3'd2, 8'h00, 1'b1, 3'd5, 8'h1E, 32'h14);
        add_row(OP_SUB,   3'd6, 3'd2, 3'd1, 8'h00, 1'b1, 3'd6, 8'hE2, 32'h18); // wraps below 0
        add_row(OP_AND,   3'd7, 3'd1, 3'd2, 8'h00, 1'b1, 3'd7, 8'h18, 32'h1C);
        add_row(OP_OR,    3'd0, 3'd1, 3'd2, 8'h00, 1'b1, 3'd0, 8'h7E, 32'h20);
        add_row(OP_BEQ,   3'd0, 3'd1, 3'd3, 8'h03, 1'b0, 3'd0, 8'h00, 32'h30); // taken
        add_row(OP_BEQ,   3'd0, 3'd1, 3'd2, 8'h05, 1'b0, 3'd0, 8'h00, 32'h34);
        add_row(OP_BNE,   3'd0, 3'd1, 3'd2, 8'h02, 1'b0, 3'd0, 8'h00, 32'h40); // taken
        add_row(OP_BNE,   3'd0, 3'd3, 3'd1, 8'h07, 1'b0, 3'd0, 8'h00, 32'h44);
        add_row(OP_JUMP,  3'd0, 3'd0, 3'd0, 8'hFB, 1'b0, 3'd0, 8'h00, 32'h34); // back 5 words
        add_row(8'h09,    3'd2, 3'd1, 3'd2, 8'h00, 1'b0, 3'd0, 8'h00, 32'h38);
        add_row(OP_ADD,   3'd1, 3'd1, 3'd6, 8'h00, 1'b1, 3'd1, 8'h3C, 32'h3C); // 5a + e2
        add_row(8'hFF,    3'd4, 3'd0, 3'd0, 8'h00, 1'b0, 3'd0, 8'h00, 32'h40);
        add_row(OP_BEQ,   3'd0, 3'd1, 3'd2, 8'hFE, 1'b0, 3'd0, 8'h00, 32'h3C); // backward
        add_row(OP_OR,    3'd2, 3'd0, 3'd4, 8'h00, 1'b1, 3'd2, 8'hFE, 32'h40);
        add_row(OP_MOV,   3'd5, 3'd0, 3'd7, 8'h00, 1'b1, 3'd5, 8'h18, 32'h44);
        add_row(OP_AND,   3'd0, 3'd6, 3'd5, 8'h00, 1'b1, 3'd0, 8'h00, 32'h48);
        add_row(OP_BNE,   3'd0, 3'd0, 3'd3, 8'h01, 1'b0, 3'd0, 8'h00, 32'h50);
    endtask

    // fields placed per the instruction format, unused bits keep the filler
    function automatic instr_t encode_instr(input row_t r, input instr_t filler);
        instr_t word;
        word        = filler;
        word[31:24] = r.opcode;
        if (r.opcode == OP_JUMP || r.opcode == OP_BEQ || r.opcode == OP_BNE)
        begin
            word[23:16] = r.imm_off;
            word[10:8]  = r.src1;
            word[2:0]   = r.src2;
        end
        else if (r.opcode == OP_LOADI)
        begin
            word[18:16] = r.dest;
            word[7:0]   = r.imm_off;
        end
        else
        begin
            word[18:16] = r.dest;
            word[10:8]  = r.src1;
            word[2:0]   = r.src2;
        end
        return word;
    endfunction

    task automatic check_wb(input wb_t actual, input wb_t expected, input string ctx);
        logic bad;
        checks++;
        bad = (actual.valid !== expected.valid);
        if (expected.valid)
        begin
            bad = bad | (actual.addr !== expected.addr) | (actual.data !== expected.data);
        end
        if (bad)
        begin
            errors++;
            $display("error at %0d ns (%s): wb valid/addr/data expected %b/%0d/%h, got %b/%0d/%h",
                     $time, ctx, expected.valid, expected.addr, expected.data,
                     actual.valid, actual.addr, actual.data);
        end
    endtask

    task automatic check_pc(input pc_t actual, input pc_t expected, input string ctx);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("error at %0d ns (%s): pc expected %h, got %h",
                     $time, ctx, expected, actual);
        end
    endtask

    task automatic run_reset(output logic ok);
        int  edges;
        wb_t idle;
        edges = 0;
        idle  = '0;
        RESET = 1'b1;
        // wait for the first reset edge to load the start address
        do
        begin
            @(negedge CLK);
            edges++;
        end
        while (pc !== START_PC && edges < RESET_TIMEOUT);
        if (pc !== START_PC)
        begin
            $display("timeout: pc did not reach the start address while RESET was held");
            errors++;
            ok = 1'b0;
        end
        else
        begin
            ok = 1'b1;
            check_wb(wb, idle, "reset");
            while (edges < RESET_CYCLES)
            begin
                instruction        = $random(seed);
                instruction[31:24] = 8'(edges % 6); // writing opcodes only
                @(negedge CLK);
                edges++;
                check_pc(pc, START_PC, "reset");
                check_wb(wb, idle, "reset");
            end
            RESET = 1'b0;
        end
    endtask

    task automatic run_table();
        row_t  r;
        string ctx;
        pc_t   start;
        start = START_PC;
        for (int i = 0; i < table_rows.size(); i++)
        begin
            r   = table_rows[i];
            ctx = $sformatf("row %0d", i);
            check_pc(pc, start, ctx);
            instruction = encode_instr(r, $random(seed));
            #(CLK_PERIOD/4); // combinational write-back settles
            check_wb(wb, r.exp_wb, ctx);
            @(posedge CLK);
            @(negedge CLK);
            check_pc(pc, r.exp_pc, ctx);
            start = r.exp_pc;
        end
    endtask

    task automatic finish_run();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    endtask

    initial
    begin
        CLK         = 1'b0;
        RESET       = 1'b1;
        instruction = '0;
        seed        = 92264;
        checks      = 0;
        errors      = 0;
        load_table();
        run_reset(reset_ok);
        if (reset_ok)
        begin
            run_table();
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- cpu8.f
design/cpu8_pkg.sv
design/instr_decoder.sv
design/reg_file.sv
design/alu.sv
design/target_calc.sv
design/pc_unit.sv
design/cpu8_top.sv
bench/cpu8_tb.sv

//--- Bender.yml
package:
  name: cpu8

sources:
  - files:
      - design/cpu8_pkg.sv
      - design/instr_decoder.sv
      - design/reg_file.sv
      - design/alu.sv
      - design/target_calc.sv
      - design/pc_unit.sv
      - design/cpu8_top.sv
  - target: test
    files:
      - bench/cpu8_tb.sv
